// File: hw/pmu_reg_pkg.sv
/*
 * PMU register map: address and data types, register addresses
 * and the layout of the 24-bit AVR SPI frame
 */
package pmu_reg_pkg;

  typedef logic [6:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // Register addresses
  localparam reg_addr_t addr_id         = 7'h00;
  localparam reg_addr_t addr_scratch    = 7'h01;
  localparam reg_addr_t addr_irq_status = 7'h02;
  localparam reg_addr_t addr_irq_mask   = 7'h03;
  localparam reg_addr_t addr_pps_count  = 7'h04;
  localparam reg_addr_t addr_button     = 7'h05;

  // SPI frame, MSB first: {rd, addr[6:0], data[15:0]}
  localparam int spi_frame_bits = 24;
  localparam int spi_cmd_bits   = 8;
  localparam int spi_rd_bit     = 23;
  localparam int spi_addr_lsb   = 16;

endpackage

// File: hw/pmu_event_pkg.sv
/*
 * Panel and timing event vector, shared by the event logic
 * and the IRQ status and mask registers
 */
package pmu_event_pkg;

  localparam int num_events = 3;

  // One single-cycle pulse per event
  typedef logic [num_events-1:0] event_vec_t;

  // Bit positions, also used for IRQ_STATUS and IRQ_MASK
  localparam int ev_press   = 0;
  localparam int ev_release = 1;
  localparam int ev_pps     = 2;

endpackage

// File: hw/reg_bus_if.sv
/*
 * Request/acknowledge register bus between requesters,
 * the arbiter and the register file
 */
`timescale 1ns/1ps

interface reg_bus_if;
  import pmu_reg_pkg::*;

  logic      req;
  logic      we;
  reg_addr_t addr;
  reg_data_t wdata;
  reg_data_t rdata;
  // Single-cycle pulse, rdata valid with it on reads
  logic      ack;

  modport requester (
    output req, we, addr, wdata,
    input  rdata, ack
  );

  modport responder (
    input  req, we, addr, wdata,
    output rdata, ack
  );

endinterface

// File: hw/panel_events.sv
/*
 * Panel events: synchronizes the on-switch and PPS inputs and
 * turns qualified edges into press, release and PPS pulses
 */
`timescale 1ns/1ps

module panel_events #(
  parameter int unsigned STABLE_CYCLES = 2
) (
  input  logic                      bus_clk,
  input  logic                      bus_rst,
  input  logic                      onswitch_n,
  input  logic                      pps,
  output pmu_event_pkg::event_vec_t events,
  output logic                      button_held,
  output logic                      pps_level
);
  import pmu_event_pkg::*;

  localparam int cnt_w = $clog2(STABLE_CYCLES + 1);
  // Bit 0 switch released (high), bit 1 PPS low
  localparam logic [1:0] idle_level = 2'b01;

  logic [1:0] sync_a;
  logic [1:0] sync_b;
  wire  [1:0] level;
  // One-cycle pulse when a new level is accepted
  wire  [1:0] accept;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      sync_a <= idle_level;
      sync_b <= idle_level;
    end else begin
      sync_a <= {pps, onswitch_n};
      sync_b <= sync_a;
    end
  end

  // ----------------------------------------
  // Per-input stability qualifier
  // ----------------------------------------
  for (genvar i = 0; i < 2; i++) begin : g_qual
    logic             lvl;
    logic [cnt_w-1:0] cnt;
    logic             acc_q;

    always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
        lvl   <= idle_level[i];
        cnt   <= '0;
        acc_q <= 1'b0;
      end else begin
        acc_q <= 1'b0;
        if (sync_b[i] == lvl) begin
          cnt <= '0;
        end else if (cnt == cnt_w'(STABLE_CYCLES - 1)) begin
          // New level held long enough
          lvl   <= sync_b[i];
          cnt   <= '0;
          acc_q <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end

    assign level[i]  = lvl;
    assign accept[i] = acc_q;
  end

  always_comb begin
    events             = '0;
    // The accepted level gives the direction of the edge
    events[ev_press]   = accept[0] & ~level[0];
    events[ev_release] = accept[0] & level[0];
    events[ev_pps]     = accept[1] & level[1];
  end

  // Switch input is active low
  assign button_held = ~level[0];
  assign pps_level   = sync_b[1];

endmodule

// File: hw/avr_spi_slave.sv
/*
 * AVR SPI slave, mode 0: turns 24-bit frames from the power
 * management controller into register bus reads and writes
 */
`timescale 1ns/1ps

module avr_spi_slave (
  input  logic         bus_clk,
  input  logic         bus_rst,
  input  logic         cs_n,
  input  logic         sck,
  input  logic         mosi,
  output logic         miso,
  reg_bus_if.requester bus
);
  import pmu_reg_pkg::*;

  localparam int cnt_w = $clog2(spi_frame_bits + 1);

  logic [2:0]                sync_a;
  logic [2:0]                sync_b;
  logic                      sck_d;
  logic                      cs_s;
  logic                      sck_s;
  logic                      mosi_s;
  logic                      sck_rise;
  logic                      sck_fall;
  logic [cnt_w-1:0]          bit_cnt;
  logic [spi_frame_bits-2:0] shift_in;
  logic [spi_frame_bits-1:0] shift_next;
  logic                      cmd_rd;
  logic                      frame_wr;
  reg_data_t                 shift_out;
  logic                      req_q;
  logic                      we_q;
  reg_addr_t                 addr_q;
  reg_data_t                 wdata_q;

  // Synchronizers, idle with cs_n high
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      sync_a <= 3'b100;
      sync_b <= 3'b100;
      sck_d  <= 1'b0;
    end else begin
      sync_a <= {cs_n, sck, mosi};
      sync_b <= sync_a;
      sck_d  <= sck_s;
    end
  end

  assign {cs_s, sck_s, mosi_s} = sync_b;
  assign sck_rise   = sck_s & ~sck_d;
  assign sck_fall   = ~sck_s & sck_d;
  assign shift_next = {shift_in, mosi_s};

  // Read issues after the command byte, write after the whole frame
  assign cmd_rd   = sck_rise && !cs_s && bit_cnt == cnt_w'(spi_cmd_bits - 1) &&
                    shift_next[spi_cmd_bits-1];
  assign frame_wr = sck_rise && !cs_s && bit_cnt == cnt_w'(spi_frame_bits - 1) &&
                    !shift_next[spi_rd_bit];

  // ----------------------------------------
  // Frame receive and request
  // ----------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      bit_cnt <= '0;
      req_q   <= 1'b0;
    end else begin
      if (cs_s) begin
        bit_cnt <= '0;
      end else if (sck_rise && bit_cnt != cnt_w'(spi_frame_bits)) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      // Held until ack, even if the frame is aborted meanwhile
      if (cmd_rd || frame_wr) begin
        req_q <= 1'b1;
      end else if (bus.ack) begin
        req_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (sck_rise && !cs_s) begin
      shift_in <= shift_next[spi_frame_bits-2:0];
    end
    if (cmd_rd || frame_wr) begin
      we_q    <= frame_wr;
      addr_q  <= frame_wr ? shift_next[spi_rd_bit-1:spi_addr_lsb]
                          : shift_next[spi_cmd_bits-2:0];
      wdata_q <= shift_next[spi_addr_lsb-1:0];
    end
  end

  // ----------------------------------------
  // Read data out, changes on falling sck
  // ----------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst || cs_s) begin
      shift_out <= '0;
      miso      <= 1'b0;
    end else if (req_q && bus.ack && !we_q) begin
      shift_out <= bus.rdata;
    end else if (sck_fall) begin
      miso      <= shift_out[$bits(reg_data_t)-1];
      shift_out <= shift_out << 1;
    end
  end

  assign bus.req   = req_q;
  assign bus.we    = we_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;

endmodule

// File: hw/reg_arbiter.sv
/*
 * Two-way register bus arbiter with alternating priority
 * between the host port and the SPI slave
 */
`timescale 1ns/1ps

module reg_arbiter (
  input  logic         bus_clk,
  input  logic         bus_rst,
  reg_bus_if.responder host,
  reg_bus_if.responder spi,
  reg_bus_if.requester regs
);

  typedef enum logic {
    st_idle,
    st_busy
  } state_t;

  state_t state;
  logic   sel_spi;
  logic   last_spi;
  // Blocks a new grant in the cycle after ack
  logic   hold;
  logic   busy;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state    <= st_idle;
      sel_spi  <= 1'b0;
      last_spi <= 1'b1;
      hold     <= 1'b0;
    end else begin
      hold <= 1'b0;
      case (state)
        st_idle: begin
          if (!hold && (host.req || spi.req)) begin
            state   <= st_busy;
            // Both present: serve the one not served last
            sel_spi <= spi.req && (!host.req || !last_spi);
          end
        end
        st_busy: begin
          if (regs.ack) begin
            state    <= st_idle;
            last_spi <= sel_spi;
            hold     <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign busy = (state == st_busy);

  // ----------------------------------------
  // Request mux and response routing
  // ----------------------------------------
  assign regs.req   = busy && (sel_spi ? spi.req : host.req);
  assign regs.we    = sel_spi ? spi.we    : host.we;
  assign regs.addr  = sel_spi ? spi.addr  : host.addr;
  assign regs.wdata = sel_spi ? spi.wdata : host.wdata;

  assign host.ack   = busy && !sel_spi && regs.ack;
  assign spi.ack    = busy && sel_spi && regs.ack;
  assign host.rdata = (busy && !sel_spi) ? regs.rdata : '0;
  assign spi.rdata  = (busy && sel_spi) ? regs.rdata : '0;

endmodule

// File: hw/pmu_regs.sv
/*
 * PMU register file: ID, scratch, sticky IRQ status with
 * write-one-to-clear, IRQ mask, PPS counter and button state
 */
`timescale 1ns/1ps

module pmu_regs #(
  parameter pmu_reg_pkg::reg_data_t FW_VERSION = 16'h0100
) (
  input  logic                      bus_clk,
  input  logic                      bus_rst,
  input  pmu_event_pkg::event_vec_t events,
  input  logic                      button_held,
  reg_bus_if.responder              bus,
  output logic                      irq
);
  import pmu_reg_pkg::*;
  import pmu_event_pkg::*;

  reg_data_t  scratch;
  reg_data_t  pps_count;
  reg_data_t  rd_val;
  reg_data_t  rdata_q;
  event_vec_t status;
  event_vec_t mask;
  event_vec_t w1c;
  logic       ack_q;
  logic       access;
  logic       wr;

  // One ack per held request
  assign access = bus.req && !ack_q;
  assign wr     = access && bus.we;
  assign w1c    = (wr && bus.addr == addr_irq_status) ? bus.wdata[num_events-1:0] : '0;

  always_comb begin
    case (bus.addr)
      addr_id:         rd_val = FW_VERSION;
      addr_scratch:    rd_val = scratch;
      addr_irq_status: rd_val = reg_data_t'(status);
      addr_irq_mask:   rd_val = reg_data_t'(mask);
      addr_pps_count:  rd_val = pps_count;
      addr_button:     rd_val = reg_data_t'(button_held);
      default:         rd_val = '0;
    endcase
  end

  // ----------------------------------------
  // Control state and interrupt
  // ----------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      ack_q     <= 1'b0;
      mask      <= '0;
      status    <= '0;
      pps_count <= '0;
      irq       <= 1'b0;
    end else begin
      ack_q <= access;
      if (wr && bus.addr == addr_irq_mask) begin
        mask <= bus.wdata[num_events-1:0];
      end
      // A new event wins over a clear of the same bit
      status <= (status & ~w1c) | events;
      if (events[ev_pps]) begin
        pps_count <= pps_count + 1'b1;
      end
      irq <= |(status & mask);
    end
  end

  always_ff @(posedge bus_clk) begin
    if (access) begin
      rdata_q <= rd_val;
    end
    if (wr && bus.addr == addr_scratch) begin
      scratch <= bus.wdata;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = rdata_q;

endmodule

// File: hw/pmu_top.sv
/*
 * PMU housekeeping top: panel events, AVR SPI slave and host
 * port sharing one register file through an arbiter
 */
`timescale 1ns/1ps

module pmu_top #(
  parameter pmu_reg_pkg::reg_data_t FW_VERSION    = 16'h0100,
  parameter int unsigned            STABLE_CYCLES = 2
) (
  input  logic                   bus_clk,
  input  logic                   bus_rst,
  input  logic                   host_req,
  input  logic                   host_we,
  input  pmu_reg_pkg::reg_addr_t host_addr,
  input  pmu_reg_pkg::reg_data_t host_wdata,
  output pmu_reg_pkg::reg_data_t host_rdata,
  output logic                   host_ack,
  input  logic                   onswitch_n,
  input  logic                   pps,
  input  logic                   avr_cs_n,
  input  logic                   avr_sck,
  input  logic                   avr_mosi,
  output logic                   avr_miso,
  output logic                   irq,
  output logic                   pps_level
);
  import pmu_event_pkg::*;

  event_vec_t events;
  logic       button_held;

  reg_bus_if host_bus ();
  reg_bus_if spi_bus ();
  reg_bus_if regs_bus ();

  // Host port onto its bus
  assign host_bus.req   = host_req;
  assign host_bus.we    = host_we;
  assign host_bus.addr  = host_addr;
  assign host_bus.wdata = host_wdata;
  assign host_rdata     = host_bus.rdata;
  assign host_ack       = host_bus.ack;

  panel_events #(
    .STABLE_CYCLES (STABLE_CYCLES)
  ) u_panel_events (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .onswitch_n  (onswitch_n),
    .pps         (pps),
    .events      (events),
    .button_held (button_held),
    .pps_level   (pps_level)
  );

  avr_spi_slave u_avr_spi_slave (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .cs_n    (avr_cs_n),
    .sck     (avr_sck),
    .mosi    (avr_mosi),
    .miso    (avr_miso),
    .bus     (spi_bus.requester)
  );

  reg_arbiter u_reg_arbiter (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .host    (host_bus.responder),
    .spi     (spi_bus.responder),
    .regs    (regs_bus.requester)
  );

  pmu_regs #(
    .FW_VERSION (FW_VERSION)
  ) u_pmu_regs (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .events      (events),
    .button_held (button_held),
    .bus         (regs_bus.responder),
    .irq         (irq)
  );

endmodule

// File: dv/pmu_tb.sv
/*
 * PMU housekeeping testbench: host and SPI register access,
 * panel events, interrupts and arbitration under load
 */
`timescale 1ns/1ps

module pmu_tb;
  import pmu_reg_pkg::*;

  localparam reg_data_t fw_version      = 16'h0E30;
  localparam int        half_period     = 10;
  localparam int        ack_timeout     = 64;
  // Tests run about 3500 cycles, mostly SPI frames of about 500 cycles each
  localparam int        watchdog_cycles = 20000;

  logic      bus_clk;
  logic      bus_rst;
  logic      host_req;
  logic      host_we;
  reg_addr_t host_addr;
  reg_data_t host_wdata;
  reg_data_t host_rdata;
  logic      host_ack;
  logic      onswitch_n;
  logic      pps;
  logic      avr_cs_n;
  logic      avr_sck;
  logic      avr_mosi;
  logic      avr_miso;
  logic      irq;
  logic      pps_level;

  integer    seed;
  int        err_count;
  logic      spi_active;

  pmu_top #(
    .FW_VERSION    (fw_version),
    .STABLE_CYCLES (2)
  ) u_dut (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .host_req   (host_req),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .host_ack   (host_ack),
    .onswitch_n (onswitch_n),
    .pps        (pps),
    .avr_cs_n   (avr_cs_n),
    .avr_sck    (avr_sck),
    .avr_mosi   (avr_mosi),
    .avr_miso   (avr_miso),
    .irq        (irq),
    .pps_level  (pps_level)
  );

  always #4 bus_clk = ~bus_clk;

  // ----------------------------------------
  // Checks and bus helpers
  // ----------------------------------------
  task automatic report_failure(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [15:0] got,
                          input logic [15:0] exp);
    if (got !== exp) begin
      err_count++;
      report_failure($sformatf("[ERROR] %0t ns %s: got 0x%04h, expected 0x%04h",
                               $time, name, got, exp));
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge bus_clk);
  endtask

  // Request held until ack, dropped in the ack cycle
  task automatic host_access(input logic we, input reg_addr_t addr,
                             input reg_data_t wdata, output reg_data_t rdata);
    int waited;
    waited = 0;
    @(negedge bus_clk);
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    do begin
      @(negedge bus_clk);
      waited++;
      if (waited > ack_timeout) begin
        report_failure("host register access received no ack");
      end
    end while (!host_ack);
    rdata    = host_rdata;
    host_req = 1'b0;
    host_we  = 1'b0;
  endtask

  task automatic host_write(input reg_addr_t addr, input reg_data_t data);
    reg_data_t unused;
    host_access(1'b1, addr, data, unused);
  endtask

  task automatic host_read(input reg_addr_t addr, output reg_data_t data);
    host_access(1'b0, addr, 16'h0000, data);
  endtask

  task automatic expect_reg(input string name, input reg_addr_t addr,
                            input reg_data_t exp);
    reg_data_t data;
    host_read(addr, data);
    check_eq(name, data, exp);
  endtask

  // Mode 0 master, miso sampled on each rising sck
  task automatic spi_xfer(input logic [23:0] frame, input int nbits,
                          output logic [23:0] rx);
    logic [23:0] tx;
    tx = frame;
    rx = '0;
    @(negedge bus_clk);
    avr_cs_n = 1'b0;
    for (int i = 0; i < nbits; i++) begin
      avr_mosi = tx[23];
      tx       = tx << 1;
      wait_cycles(half_period);
      rx      = {rx[22:0], avr_miso};
      avr_sck = 1'b1;
      wait_cycles(half_period);
      avr_sck = 1'b0;
    end
    wait_cycles(half_period);
    avr_cs_n = 1'b1;
    avr_mosi = 1'b0;
    wait_cycles(half_period);
  endtask

  task automatic spi_write(input reg_addr_t addr, input reg_data_t data);
    logic [23:0] rx;
    spi_xfer({1'b0, addr, data}, 24, rx);
  endtask

  task automatic spi_read(input reg_addr_t addr, output reg_data_t data);
    logic [23:0] rx;
    spi_xfer({1'b1, addr, 16'h0000}, 24, rx);
    check_eq("avr_miso during command", {8'h00, rx[23:16]}, 16'h0000);
    data = rx[15:0];
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic reset_defaults();
    check_eq("irq", 16'(irq), 16'h0000);
    check_eq("host_ack", 16'(host_ack), 16'h0000);
    check_eq("avr_miso", 16'(avr_miso), 16'h0000);
    expect_reg("id", addr_id, fw_version);
    expect_reg("irq_mask", addr_irq_mask, 16'h0000);
    expect_reg("irq_status", addr_irq_status, 16'h0000);
    expect_reg("pps_count", addr_pps_count, 16'h0000);
    expect_reg("button", addr_button, 16'h0000);
  endtask

  task automatic scratch_readback();
    reg_data_t value;
    value = '0;
    for (int i = 0; i < 8; i++) begin
      value = 16'($random(seed));
      host_write(addr_scratch, value);
      expect_reg("scratch", addr_scratch, value);
    end
    // Writes to read-only or unmapped addresses change nothing
    host_write(7'h10, 16'hFFFF);
    host_write(addr_id, 16'h1234);
    expect_reg("id after write", addr_id, fw_version);
    expect_reg("scratch after stray writes", addr_scratch, value);
    expect_reg("unmapped 0x06", 7'h06, 16'h0000);
    expect_reg("unmapped 0x10", 7'h10, 16'h0000);
    expect_reg("unmapped 0x7f", 7'h7F, 16'h0000);
  endtask

  task automatic spi_frames();
    reg_data_t   data;
    logic [23:0] rx;
    spi_write(addr_scratch, 16'h5A3C);
    expect_reg("scratch after spi write", addr_scratch, 16'h5A3C);
    host_write(addr_scratch, 16'hC3A5);
    spi_read(addr_scratch, data);
    check_eq("spi read of scratch", data, 16'hC3A5);
    // Write frame cut off after 12 bits
    spi_xfer({1'b0, addr_scratch, 16'h1111}, 12, rx);
    expect_reg("scratch after aborted frame", addr_scratch, 16'hC3A5);
    spi_read(addr_id, data);
    check_eq("spi read of id", data, fw_version);
  endtask

  task automatic button_and_irq();
    host_write(addr_irq_mask, 16'h0000);
    host_write(addr_irq_status, 16'h0007);
    @(negedge bus_clk);
    onswitch_n = 1'b0;
    @(negedge bus_clk);
    onswitch_n = 1'b1;
    wait_cycles(8);
    expect_reg("irq_status after glitch", addr_irq_status, 16'h0000);
    expect_reg("button after glitch", addr_button, 16'h0000);
    onswitch_n = 1'b0;
    wait_cycles(8);
    expect_reg("irq_status after press", addr_irq_status, 16'h0001);
    expect_reg("button while held", addr_button, 16'h0001);
    check_eq("irq with mask clear", 16'(irq), 16'h0000);
    onswitch_n = 1'b1;
    wait_cycles(8);
    expect_reg("irq_status after release", addr_irq_status, 16'h0003);
    expect_reg("button after release", addr_button, 16'h0000);
    host_write(addr_irq_mask, 16'h0004);
    wait_cycles(2);
    check_eq("irq with only pps unmasked", 16'(irq), 16'h0000);
    host_write(addr_irq_mask, 16'h0002);
    wait_cycles(2);
    check_eq("irq with release unmasked", 16'(irq), 16'h0001);
    host_write(addr_irq_status, 16'h0001);
    expect_reg("irq_status after clearing bit 0", addr_irq_status, 16'h0002);
    check_eq("irq after clearing bit 0", 16'(irq), 16'h0001);
    host_write(addr_irq_status, 16'h0002);
    expect_reg("irq_status after clearing bit 1", addr_irq_status, 16'h0000);
    check_eq("irq after clearing bit 1", 16'(irq), 16'h0000);
    host_write(addr_irq_mask, 16'h0000);
  endtask

  task automatic pps_count_check();
    int n_pulses;
    n_pulses = 3 + ($random(seed) & 3);
    for (int i = 0; i < n_pulses; i++) begin
      pps = 1'b1;
      wait_cycles(6);
      check_eq("pps_level high", 16'(pps_level), 16'h0001);
      pps = 1'b0;
      wait_cycles(6);
      check_eq("pps_level low", 16'(pps_level), 16'h0000);
    end
    // No PPS pulse before this test, so the count starts from reset
    expect_reg("pps_count", addr_pps_count, 16'(n_pulses));
    expect_reg("irq_status after pps", addr_irq_status, 16'h0004);
    host_write(addr_irq_status, 16'h0004);
  endtask

  task automatic arbitration_under_load();
    reg_data_t spi_data;
    host_write(addr_scratch, 16'h9E17);
    spi_active = 1'b1;
    fork
      begin
        spi_read(addr_scratch, spi_data);
        check_eq("spi scratch under load", spi_data, 16'h9E17);
        spi_read(addr_id, spi_data);
        check_eq("spi id under load", spi_data, fw_version);
        spi_active = 1'b0;
      end
      begin
        while (spi_active) begin
          expect_reg("scratch under load", addr_scratch, 16'h9E17);
          expect_reg("id under load", addr_id, fw_version);
        end
      end
    join
  endtask

  // ----------------------------------------
  // Sequence and watchdog
  // ----------------------------------------
  initial begin
    seed       = 66565;
    err_count  = 0;
    spi_active = 1'b0;
    bus_clk    = 1'b0;
    bus_rst    = 1'b1;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    onswitch_n = 1'b1;
    pps        = 1'b0;
    avr_cs_n   = 1'b1;
    avr_sck    = 1'b0;
    avr_mosi   = 1'b0;
    repeat (4) @(negedge bus_clk);
    bus_rst = 1'b0;

    reset_defaults();
    scratch_readback();
    spi_frames();
    button_and_irq();
    pps_count_check();
    arbitration_under_load();
    wait_cycles(4);

    if (err_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("=== FAIL ===");
      $fatal(1, "checks failed");
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge bus_clk);
    report_failure("timeout: the tests did not finish within the watchdog limit");
  end

endmodule

// File: project.f
hw/pmu_reg_pkg.sv
hw/pmu_event_pkg.sv
hw/reg_bus_if.sv
hw/panel_events.sv
hw/avr_spi_slave.sv
hw/reg_arbiter.sv
hw/pmu_regs.sv
hw/pmu_top.sv
dv/pmu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PMU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module pmu_tb -o pmu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pmu_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Simulation finished without failures"
exit 0
